/* htif_bridge_defs.svh */
//*****************************
// HTIF bridge constants
// address map, widths, UART-lite layout
//*****************************

`ifndef HTIF_BRIDGE_DEFS_SVH
`define HTIF_BRIDGE_DEFS_SVH

`define HTIF_AW 64
`define HTIF_DW 64

// HTIF registers, both nonzero
`define HTIF_TOHOST   64'h1000
`define HTIF_FROMHOST 64'h1008

// UART-lite, FIFO sits at the base
`define UART_BASE     64'h10000000
`define UART_STAT_OFS 8

`define UART_RX_VALID_BIT 0
`define UART_TX_FULL_BIT  3
`define UART_TX_STRB      4 // byte lane of the tx FIFO

// console codes in bits 63:56 and 55:48
`define CONSOLE_DEV       8'd1
`define CONSOLE_CMD_WRITE 8'd1

`endif

/* htif_pkg.sv */
//*****************************
// HTIF bridge types
// AXI channels, UART requests, FSM states
//*****************************

`include "htif_bridge_defs.svh"

package htif_pkg;

    typedef struct packed {
        logic                valid;
        logic [`HTIF_AW-1:0] addr;
        logic [7:0]          len;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        logic                  valid;
        logic [`HTIF_DW-1:0]   data;
        logic [`HTIF_DW/8-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic                valid;
        logic [`HTIF_DW-1:0] data;
        logic                last;
    } axi_r_t;

    typedef struct packed {
        logic valid;
    } axi_b_t;

    typedef enum logic [1:0] {
        UART_NONE,
        UART_TX,
        UART_RX
    } uart_op_e;

    typedef struct packed {
        uart_op_e   op;
        logic [7:0] data; // character for tx
    } uart_req_t;

    typedef struct packed {
        logic       done;
        logic       rx_valid;
        logic [7:0] rx_byte;
    } uart_result_t;

    typedef enum logic [3:0] {
        U_IDLE,
        U_POLL_AR,
        U_POLL_R,
        U_TX_AWW,
        U_TX_WAIT,
        U_TX_B,
        U_RX_AR,
        U_RX_AR_WAIT,
        U_RX_R,
        U_RECOVER
    } uart_state_e;

endpackage

/* htif_route.sv */
//*****************************
// HTIF route
// steers core AXI to memory or HTIF regs
//*****************************

`timescale 1ns/100ps
`include "htif_bridge_defs.svh"

module htif_route (
    input  logic                  clk,
    input  logic                  rst,
    input  htif_pkg::axi_aw_t     core_aw_i,
    input  htif_pkg::axi_w_t      core_w_i,
    input  htif_pkg::axi_ar_t     core_ar_i,
    input  logic                  core_b_ready_i,
    input  logic                  core_r_ready_i,
    input  logic                  slave_aw_ready_i,
    input  logic                  slave_w_ready_i,
    input  logic                  slave_ar_ready_i,
    input  htif_pkg::axi_b_t      slave_b_i,
    input  htif_pkg::axi_r_t      slave_r_i,
    input  htif_pkg::axi_aw_t     uart_aw_i,
    input  htif_pkg::axi_w_t      uart_w_i,
    input  htif_pkg::axi_ar_t     uart_ar_i,
    input  logic                  uart_b_ready_i,
    input  logic                  uart_r_ready_i,
    input  logic                  mem_aw_ready_i,
    input  logic                  mem_w_ready_i,
    input  logic                  mem_ar_ready_i,
    input  htif_pkg::axi_b_t      mem_b_i,
    input  htif_pkg::axi_r_t      mem_r_i,
    input  logic                  htif_done_i,
    output logic                  htif_sel_o,
    output logic                  core_aw_ready_o,
    output logic                  core_w_ready_o,
    output logic                  core_ar_ready_o,
    output htif_pkg::axi_b_t      core_b_o,
    output htif_pkg::axi_r_t      core_r_o,
    output htif_pkg::axi_aw_t     mem_aw_o,
    output htif_pkg::axi_w_t      mem_w_o,
    output htif_pkg::axi_ar_t     mem_ar_o,
    output logic                  mem_b_ready_o,
    output logic                  mem_r_ready_o,
    output logic                  uart_aw_ready_o,
    output logic                  uart_w_ready_o,
    output logic                  uart_ar_ready_o,
    output htif_pkg::axi_b_t      uart_b_o,
    output htif_pkg::axi_r_t      uart_r_o
);
    import htif_pkg::*;

    logic hit;
    logic win_q;

    // single beat to TOHOST or FROMHOST
    function automatic logic is_htif(input logic [`HTIF_AW-1:0] addr, input logic [7:0] len);
        return len == 8'd0 && (addr == `HTIF_TOHOST || addr == `HTIF_FROMHOST);
    endfunction

    assign hit = (core_aw_i.valid && is_htif(core_aw_i.addr, core_aw_i.len))
              || (core_ar_i.valid && is_htif(core_ar_i.addr, core_ar_i.len));
    assign htif_sel_o = hit || win_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            win_q <= 1'b0;
        end else if (htif_done_i) begin
            win_q <= 1'b0;
        end else if (hit) begin
            win_q <= 1'b1;
        end
    end

    // core side sees HTIF regs inside the window
    assign core_aw_ready_o = htif_sel_o ? slave_aw_ready_i : mem_aw_ready_i;
    assign core_w_ready_o  = htif_sel_o ? slave_w_ready_i  : mem_w_ready_i;
    assign core_ar_ready_o = htif_sel_o ? slave_ar_ready_i : mem_ar_ready_i;
    assign core_b_o        = htif_sel_o ? slave_b_i        : mem_b_i;
    assign core_r_o        = htif_sel_o ? slave_r_i        : mem_r_i;

    // memory side belongs to the UART master inside the window
    assign mem_aw_o      = htif_sel_o ? uart_aw_i      : core_aw_i;
    assign mem_w_o       = htif_sel_o ? uart_w_i       : core_w_i;
    assign mem_ar_o      = htif_sel_o ? uart_ar_i      : core_ar_i;
    assign mem_b_ready_o = htif_sel_o ? uart_b_ready_i : core_b_ready_i;
    assign mem_r_ready_o = htif_sel_o ? uart_r_ready_i : core_r_ready_i;

    assign uart_aw_ready_o = htif_sel_o && mem_aw_ready_i;
    assign uart_w_ready_o  = htif_sel_o && mem_w_ready_i;
    assign uart_ar_ready_o = htif_sel_o && mem_ar_ready_i;
    assign uart_b_o        = htif_sel_o ? mem_b_i : '0;
    assign uart_r_o        = htif_sel_o ? mem_r_i : '0;

    // a pending register response always reaches the core
    a_sel_holds: assert property (@(posedge clk) disable iff (rst)
        (slave_r_i.valid || slave_b_i.valid) |-> htif_sel_o);

endmodule

/* htif_regs.sv */
//*****************************
// HTIF registers
// TOHOST/FROMHOST slave, console requests
//*****************************

`timescale 1ns/100ps
`include "htif_bridge_defs.svh"

module htif_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   htif_sel_i,
    input  htif_pkg::axi_aw_t      core_aw_i,
    input  htif_pkg::axi_w_t       core_w_i,
    input  htif_pkg::axi_ar_t      core_ar_i,
    input  logic                   core_b_ready_i,
    input  logic                   core_r_ready_i,
    input  htif_pkg::uart_result_t uart_result_i,
    output logic                   slave_aw_ready_o,
    output logic                   slave_w_ready_o,
    output logic                   slave_ar_ready_o,
    output htif_pkg::axi_b_t       slave_b_o,
    output htif_pkg::axi_r_t       slave_r_o,
    output htif_pkg::uart_req_t    uart_req_o,
    output logic                   htif_done_o
);
    import htif_pkg::*;

    logic [`HTIF_DW-1:0] tohost_q;
    logic [`HTIF_DW-1:0] fromhost_q;
    logic [`HTIF_AW-1:0] waddr_q;
    logic [`HTIF_DW-1:0] wdata_q;
    logic [`HTIF_AW-1:0] waddr;
    logic [`HTIF_DW-1:0] wdata;
    logic aw_fire, w_fire, ar_fire, b_fire, r_fire;
    logic wr_commit;
    logic console;
    logic busy_q;    // UART action running
    logic rx_pend_q; // FROMHOST read found it empty

    assign aw_fire = htif_sel_i && core_aw_i.valid && slave_aw_ready_o;
    assign w_fire  = htif_sel_i && core_w_i.valid && slave_w_ready_o;
    assign ar_fire = htif_sel_i && core_ar_i.valid && slave_ar_ready_o;
    assign b_fire  = slave_b_o.valid && core_b_ready_i;
    assign r_fire  = slave_r_o.valid && core_r_ready_i;

    // beat of this cycle or the one held
    assign waddr = slave_aw_ready_o ? core_aw_i.addr : waddr_q;
    assign wdata = slave_w_ready_o ? core_w_i.data : wdata_q;
    assign wr_commit = !busy_q && !slave_b_o.valid
                    && (aw_fire || !slave_aw_ready_o) && (w_fire || !slave_w_ready_o);

    assign console = tohost_q[63:56] == `CONSOLE_DEV && tohost_q[55:48] == `CONSOLE_CMD_WRITE;

    assign htif_done_o = (r_fire && !rx_pend_q) || (b_fire && !console)
                      || (busy_q && uart_result_i.done);

    always_ff @(posedge clk) begin
        if (rst) begin
            tohost_q         <= '0;
            fromhost_q       <= '0;
            slave_aw_ready_o <= 1'b1;
            slave_w_ready_o  <= 1'b1;
            slave_ar_ready_o <= 1'b1;
            slave_b_o        <= '0;
            slave_r_o.valid  <= 1'b0;
            busy_q           <= 1'b0;
            rx_pend_q        <= 1'b0;
            uart_req_o       <= '{op: UART_NONE, data: 8'd0};
        end else begin
            uart_req_o.op <= UART_NONE; // request is a pulse
            if (aw_fire) begin
                slave_aw_ready_o <= 1'b0;
                waddr_q          <= core_aw_i.addr;
            end
            if (w_fire) begin
                slave_w_ready_o <= 1'b0;
                wdata_q         <= core_w_i.data;
            end
            if (wr_commit) begin
                slave_b_o.valid <= 1'b1;
                if (waddr == `HTIF_TOHOST) tohost_q <= wdata;
                if (waddr == `HTIF_FROMHOST) fromhost_q <= wdata;
            end
            if (ar_fire) begin
                slave_ar_ready_o <= 1'b0;
                slave_r_o.valid  <= 1'b1;
                slave_r_o.last   <= 1'b1;
                slave_r_o.data   <= core_ar_i.addr == `HTIF_TOHOST ? tohost_q : fromhost_q;
                if (core_ar_i.addr == `HTIF_FROMHOST && fromhost_q == '0) rx_pend_q <= 1'b1;
            end
            if (r_fire) begin
                slave_r_o.valid <= 1'b0;
                if (rx_pend_q) begin // fetch a byte while the core waits
                    busy_q           <= 1'b1;
                    slave_aw_ready_o <= 1'b0;
                    slave_w_ready_o  <= 1'b0;
                    uart_req_o.op    <= UART_RX;
                end else begin
                    slave_ar_ready_o <= 1'b1;
                end
            end
            if (b_fire) begin
                slave_b_o.valid <= 1'b0;
                if (console) begin
                    busy_q           <= 1'b1;
                    slave_ar_ready_o <= 1'b0;
                    uart_req_o       <= '{op: UART_TX, data: tohost_q[7:0]};
                end else begin
                    slave_aw_ready_o <= 1'b1;
                    slave_w_ready_o  <= 1'b1;
                    tohost_q         <= '0;
                end
            end
            if (busy_q && uart_result_i.done) begin
                busy_q           <= 1'b0;
                rx_pend_q        <= 1'b0;
                slave_aw_ready_o <= 1'b1;
                slave_w_ready_o  <= 1'b1;
                slave_ar_ready_o <= 1'b1;
                if (!rx_pend_q) begin
                    tohost_q <= '0;
                end else if (uart_result_i.rx_valid) begin
                    // byte lands in bits 7:0
                    fromhost_q <= {`CONSOLE_DEV, `CONSOLE_CMD_WRITE, 40'd0,
                                   uart_result_i.rx_byte};
                end
            end
        end
    end

endmodule

/* uart_lite_master.sv */
//*****************************
// UART-lite master
// status polling and FIFO access over AXI
//*****************************

`timescale 1ns/100ps
`include "htif_bridge_defs.svh"

module uart_lite_master (
    input  logic                   clk,
    input  logic                   rst,
    input  htif_pkg::uart_req_t    uart_req_i,
    input  logic                   aw_ready_i,
    input  logic                   w_ready_i,
    input  logic                   ar_ready_i,
    input  htif_pkg::axi_b_t       b_i,
    input  htif_pkg::axi_r_t       r_i,
    output htif_pkg::axi_aw_t      aw_o,
    output htif_pkg::axi_w_t       w_o,
    output htif_pkg::axi_ar_t      ar_o,
    output logic                   b_ready_o,
    output logic                   r_ready_o,
    output htif_pkg::uart_result_t uart_result_o
);
    import htif_pkg::*;

    localparam logic [`HTIF_AW-1:0] STAT_ADDR = `UART_BASE + `UART_STAT_OFS;

    uart_state_e state_q;
    uart_op_e    op_q;
    logic [7:0]  char_q;
    logic        rx_valid_q;
    logic [7:0]  rx_byte_q;

    assign uart_result_o = '{done: state_q == U_RECOVER, rx_valid: rx_valid_q,
                             rx_byte: rx_byte_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= U_IDLE;
            aw_o.valid <= 1'b0;
            w_o.valid  <= 1'b0;
            ar_o.valid <= 1'b0;
            b_ready_o  <= 1'b0;
            r_ready_o  <= 1'b0;
            rx_valid_q <= 1'b0;
            rx_byte_q  <= 8'd0;
        end else begin
            case (state_q)
                U_IDLE: if (uart_req_i.op != UART_NONE) begin
                    op_q       <= uart_req_i.op;
                    char_q     <= uart_req_i.data;
                    rx_valid_q <= 1'b0;
                    ar_o       <= '{valid: 1'b1, addr: STAT_ADDR, len: 8'd0};
                    state_q    <= U_POLL_AR;
                end
                U_POLL_AR: if (ar_ready_i) begin
                    ar_o.valid <= 1'b0;
                    r_ready_o  <= 1'b1;
                    state_q    <= U_POLL_R;
                end
                U_POLL_R: if (r_i.valid) begin
                    r_ready_o <= 1'b0;
                    if (op_q == UART_RX) begin
                        state_q <= r_i.data[`UART_RX_VALID_BIT] ? U_RX_AR : U_RECOVER;
                    end else if (r_i.data[`UART_TX_FULL_BIT]) begin
                        ar_o.valid <= 1'b1; // tx FIFO full, poll again
                        state_q    <= U_POLL_AR;
                    end else begin
                        state_q <= U_TX_AWW;
                    end
                end
                U_TX_AWW: begin
                    aw_o    <= '{valid: 1'b1, addr: `UART_BASE, len: 8'd0};
                    w_o     <= '{valid: 1'b1, data: {24'd0, char_q, 32'd0},
                                 strb: 8'(1 << `UART_TX_STRB), last: 1'b1};
                    state_q <= U_TX_WAIT;
                end
                U_TX_WAIT: begin
                    if (aw_ready_i) aw_o.valid <= 1'b0;
                    if (w_ready_i) w_o.valid <= 1'b0;
                    if (!aw_o.valid && !w_o.valid) begin
                        b_ready_o <= 1'b1;
                        state_q   <= U_TX_B;
                    end
                end
                U_TX_B: if (b_i.valid) begin
                    b_ready_o <= 1'b0;
                    state_q   <= U_RECOVER;
                end
                U_RX_AR: begin
                    ar_o    <= '{valid: 1'b1, addr: `UART_BASE, len: 8'd0};
                    state_q <= U_RX_AR_WAIT;
                end
                U_RX_AR_WAIT: if (ar_ready_i) begin
                    ar_o.valid <= 1'b0;
                    r_ready_o  <= 1'b1;
                    state_q    <= U_RX_R;
                end
                U_RX_R: if (r_i.valid) begin
                    r_ready_o  <= 1'b0;
                    rx_valid_q <= 1'b1;
                    rx_byte_q  <= r_i.data[7:0];
                    state_q    <= U_RECOVER;
                end
                U_RECOVER: state_q <= U_IDLE; // done pulse
                default:   state_q <= U_IDLE;
            endcase
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_o.valid && !aw_ready_i |=> aw_o.valid);
    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        w_o.valid && !w_ready_i |=> w_o.valid);

endmodule

/* htif_bridge.sv */
//*****************************
// HTIF console bridge top
//*****************************

`timescale 1ns/100ps

module htif_bridge (
    input  logic              clk,
    input  logic              rst,
    input  htif_pkg::axi_aw_t core_aw_i,
    input  htif_pkg::axi_w_t  core_w_i,
    input  htif_pkg::axi_ar_t core_ar_i,
    input  logic              core_b_ready_i,
    input  logic              core_r_ready_i,
    output logic              core_aw_ready_o,
    output logic              core_w_ready_o,
    output logic              core_ar_ready_o,
    output htif_pkg::axi_b_t  core_b_o,
    output htif_pkg::axi_r_t  core_r_o,
    output htif_pkg::axi_aw_t mem_aw_o,
    output htif_pkg::axi_w_t  mem_w_o,
    output htif_pkg::axi_ar_t mem_ar_o,
    output logic              mem_b_ready_o,
    output logic              mem_r_ready_o,
    input  logic              mem_aw_ready_i,
    input  logic              mem_w_ready_i,
    input  logic              mem_ar_ready_i,
    input  htif_pkg::axi_b_t  mem_b_i,
    input  htif_pkg::axi_r_t  mem_r_i
);
    import htif_pkg::*;

    logic         htif_sel, htif_done;
    logic         slave_aw_ready, slave_w_ready, slave_ar_ready;
    axi_b_t       slave_b;
    axi_r_t       slave_r;
    axi_aw_t      uart_aw;
    axi_w_t       uart_w;
    axi_ar_t      uart_ar;
    logic         uart_b_ready, uart_r_ready;
    logic         uart_aw_ready, uart_w_ready, uart_ar_ready;
    axi_b_t       uart_b;
    axi_r_t       uart_r;
    uart_req_t    uart_req;
    uart_result_t uart_result;

    htif_route i_route (
        .clk, .rst, .core_aw_i, .core_w_i, .core_ar_i, .core_b_ready_i, .core_r_ready_i,
        .slave_aw_ready_i(slave_aw_ready), .slave_w_ready_i(slave_w_ready),
        .slave_ar_ready_i(slave_ar_ready), .slave_b_i(slave_b), .slave_r_i(slave_r),
        .uart_aw_i(uart_aw), .uart_w_i(uart_w), .uart_ar_i(uart_ar),
        .uart_b_ready_i(uart_b_ready), .uart_r_ready_i(uart_r_ready),
        .mem_aw_ready_i, .mem_w_ready_i, .mem_ar_ready_i, .mem_b_i, .mem_r_i,
        .htif_done_i(htif_done), .htif_sel_o(htif_sel),
        .core_aw_ready_o, .core_w_ready_o, .core_ar_ready_o, .core_b_o, .core_r_o,
        .mem_aw_o, .mem_w_o, .mem_ar_o, .mem_b_ready_o, .mem_r_ready_o,
        .uart_aw_ready_o(uart_aw_ready), .uart_w_ready_o(uart_w_ready),
        .uart_ar_ready_o(uart_ar_ready), .uart_b_o(uart_b), .uart_r_o(uart_r)
    );

    htif_regs i_regs (
        .clk, .rst, .htif_sel_i(htif_sel), .core_aw_i, .core_w_i, .core_ar_i,
        .core_b_ready_i, .core_r_ready_i, .uart_result_i(uart_result),
        .slave_aw_ready_o(slave_aw_ready), .slave_w_ready_o(slave_w_ready),
        .slave_ar_ready_o(slave_ar_ready), .slave_b_o(slave_b), .slave_r_o(slave_r),
        .uart_req_o(uart_req), .htif_done_o(htif_done)
    );

    uart_lite_master i_uart (
        .clk, .rst, .uart_req_i(uart_req),
        .aw_ready_i(uart_aw_ready), .w_ready_i(uart_w_ready), .ar_ready_i(uart_ar_ready),
        .b_i(uart_b), .r_i(uart_r), .aw_o(uart_aw), .w_o(uart_w), .ar_o(uart_ar),
        .b_ready_o(uart_b_ready), .r_ready_o(uart_r_ready), .uart_result_o(uart_result)
    );

endmodule

/* tb_htif_bridge.sv */
//*****************************
// HTIF bridge testbench
// core driver, memory and UART-lite model
//*****************************

`timescale 1ns/100ps
`include "htif_bridge_defs.svh"

module tb_htif_bridge;
    import htif_pkg::*;

    typedef enum {OP_WRITE, OP_READ, OP_CONSOLE, OP_RX_ARM, OP_RX_CHECK} tb_op_e;

    localparam int NUM_ROWS   = 20;
    localparam int ROW_CYCLES = 80; // per-row bound for the watchdog
    localparam logic [63:0] TOHOST = `HTIF_TOHOST;
    localparam logic [63:0] FROMHOST = `HTIF_FROMHOST;

    logic clk, rst;
    axi_aw_t core_aw_i;
    axi_w_t  core_w_i;
    axi_ar_t core_ar_i;
    logic    core_b_ready_i, core_r_ready_i;
    logic    core_aw_ready_o, core_w_ready_o, core_ar_ready_o;
    axi_b_t  core_b_o;
    axi_r_t  core_r_o;
    axi_aw_t mem_aw_o;
    axi_w_t  mem_w_o;
    axi_ar_t mem_ar_o;
    logic    mem_b_ready_o, mem_r_ready_o;
    logic    mem_aw_ready_i, mem_w_ready_i, mem_ar_ready_i;
    axi_b_t  mem_b_i;
    axi_r_t  mem_r_i;

    // stimulus table
    tb_op_e      row_op   [NUM_ROWS];
    logic [63:0] row_addr [NUM_ROWS];
    logic [63:0] row_data [NUM_ROWS];
    logic [63:0] row_exp  [NUM_ROWS];
    string       row_name [NUM_ROWS];

    // memory and UART-lite model state
    logic [63:0] mem_q [logic [63:0]];
    logic [63:0] tx_data_q [$];
    logic [7:0]  tx_strb_q [$];
    int          uart_acc;
    int          tx_full_left;
    logic        rx_avail;
    logic [7:0]  rx_byte;
    logic        armed_valid;
    logic [7:0]  armed_byte;
    logic [31:0] lfsr_q;
    int          n_checks, val_errs, other_errs;

    logic        ar_f, aw_f, w_f, r_f, b_f, have_aw, have_w;
    logic [63:0] ar_addr, aw_addr, wr_addr, w_data, wr_data;
    logic [7:0]  w_strb, wr_strb;

    htif_bridge i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #((NUM_ROWS * ROW_CYCLES + 40) * 8);
        $display("timeout: the run did not finish within the expected time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = 8'd0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[6:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] fill_word(input logic [63:0] a);
        return {~a[31:0], a[31:0]};
    endfunction

    function automatic logic [63:0] read_word(input logic [63:0] a);
        logic [63:0] d;
        d = '0;
        if (a == `UART_BASE + `UART_STAT_OFS) begin
            uart_acc++;
            d[`UART_TX_FULL_BIT]  = tx_full_left != 0;
            d[`UART_RX_VALID_BIT] = rx_avail;
            if (tx_full_left != 0) tx_full_left--;
        end else if (a == `UART_BASE) begin
            uart_acc++;
            d[7:0]   = rx_byte; // FIFO pop
            rx_avail = 1'b0;
        end else if (mem_q.exists(a)) begin
            d = mem_q[a];
        end else begin
            d = fill_word(a);
        end
        return d;
    endfunction

    function automatic void write_word(input logic [63:0] a, input logic [63:0] d,
                                       input logic [7:0] s);
        logic [63:0] old;
        old = mem_q.exists(a) ? mem_q[a] : fill_word(a);
        if (a == `UART_BASE) begin
            uart_acc++;
            tx_data_q.push_back(d);
            tx_strb_q.push_back(s);
        end else begin
            for (int b = 0; b < 8; b++) begin
                if (s[b]) old[b*8 +: 8] = d[b*8 +: 8];
            end
            mem_q[a] = old;
        end
    endfunction

    // memory side; fires seen before a rising edge are applied at the next falling edge
    initial begin
        {ar_f, aw_f, w_f, r_f, b_f, have_aw, have_w} = '0;
        forever begin
            @(negedge clk);
            if (r_f) mem_r_i.valid = 1'b0;
            if (ar_f) mem_r_i = '{valid: 1'b1, data: read_word(ar_addr), last: 1'b1};
            if (b_f) mem_b_i.valid = 1'b0;
            if (aw_f) begin
                have_aw = 1'b1;
                wr_addr = aw_addr;
            end
            if (w_f) begin
                have_w  = 1'b1;
                wr_data = w_data;
                wr_strb = w_strb;
            end
            if (have_aw && have_w) begin
                write_word(wr_addr, wr_data, wr_strb);
                {have_aw, have_w} = 2'b00;
                mem_b_i.valid = 1'b1;
            end
            #2;
            ar_f    = !rst && mem_ar_o.valid && mem_ar_ready_i;
            aw_f    = !rst && mem_aw_o.valid && mem_aw_ready_i;
            w_f     = !rst && mem_w_o.valid && mem_w_ready_i;
            r_f     = !rst && mem_r_i.valid && mem_r_ready_o;
            b_f     = !rst && mem_b_i.valid && mem_b_ready_o;
            ar_addr = mem_ar_o.addr;
            aw_addr = mem_aw_o.addr;
            w_data  = mem_w_o.data;
            w_strb  = mem_w_o.strb;
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        n_checks++;
        assert (got === exp) else begin
            val_errs++;
            $display("ERR %s expected %h actual %h", name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        n_checks++;
        assert (cond) else begin
            other_errs++;
            $display("failure: %s", what);
        end
    endtask

    task automatic write_op(input logic [63:0] addr, input logic [63:0] data);
        logic aw_done, w_done, aw_now, w_now, got;
        {aw_done, w_done} = 2'b00;
        @(negedge clk);
        core_aw_i = '{valid: 1'b1, addr: addr, len: 8'd0};
        core_w_i  = '{valid: 1'b1, data: data, strb: 8'hff, last: 1'b1};
        while (!(aw_done && w_done)) begin
            #1;
            aw_now = core_aw_i.valid && core_aw_ready_o;
            w_now  = core_w_i.valid && core_w_ready_o;
            @(negedge clk);
            if (aw_now) begin
                aw_done = 1'b1;
                core_aw_i.valid = 1'b0;
            end
            if (w_now) begin
                w_done = 1'b1;
                core_w_i.valid = 1'b0;
            end
        end
        core_b_ready_i = 1'b1;
        do begin
            #1;
            got = core_b_o.valid;
            @(negedge clk);
        end while (!got);
        core_b_ready_i = 1'b0;
    endtask

    task automatic read_op(input logic [63:0] addr, output logic [63:0] data);
        logic now, got;
        @(negedge clk);
        core_ar_i = '{valid: 1'b1, addr: addr, len: 8'd0};
        do begin
            #1;
            now = core_ar_ready_o;
            @(negedge clk);
        end while (!now);
        core_ar_i.valid = 1'b0;
        core_r_ready_i  = 1'b1;
        do begin
            #1;
            got  = core_r_o.valid;
            data = core_r_o.data;
            @(negedge clk);
        end while (!got);
        core_r_ready_i = 1'b0;
    endtask

    // a UART action ends when the core readies come back
    task automatic wait_idle();
        #1;
        while (!(core_aw_ready_o && core_w_ready_o && core_ar_ready_o)) begin
            @(negedge clk);
            #1;
        end
    endtask

    task automatic set_row(input int i, input tb_op_e op, input logic [63:0] addr,
                           input logic [63:0] data, input logic [63:0] exp, input string name);
        row_op[i]   = op;
        row_addr[i] = addr;
        row_data[i] = data;
        row_exp[i]  = exp;
        row_name[i] = name;
    endtask

    task automatic apply_row(input int i);
        logic [63:0] got;
        logic [63:0] exp;
        int acc0, tx0;
        acc0 = uart_acc;
        tx0  = tx_data_q.size();
        case (row_op[i])
            OP_WRITE: begin
                write_op(row_addr[i], row_data[i]);
                wait_idle();
                check_true(tx_data_q.size() == tx0, {row_name[i], ": unexpected UART write"});
                if (row_addr[i] != FROMHOST)
                    check_true(uart_acc == acc0, {row_name[i], ": unexpected UART access"});
            end
            OP_READ: begin
                read_op(row_addr[i], got);
                wait_idle();
                check_value(row_name[i], row_exp[i], got);
                if (row_addr[i] != FROMHOST)
                    check_true(uart_acc == acc0, {row_name[i], ": unexpected UART access"});
            end
            OP_CONSOLE: begin
                tx_full_left = int'(take_bits(2));
                write_op(TOHOST, {`CONSOLE_DEV, `CONSOLE_CMD_WRITE, 40'd0, row_data[i][7:0]});
                wait_idle();
                check_true(tx_data_q.size() == tx0 + 1, {row_name[i], ": no single FIFO write"});
                check_true(tx_full_left == 0, {row_name[i], ": not all full polls seen"});
                if (tx_data_q.size() == tx0 + 1) begin
                    check_value({row_name[i], "_strb"}, 64'h10, 64'(tx_strb_q[tx0]));
                    check_value({row_name[i], "_char"}, 64'(row_data[i][7:0]),
                                64'(tx_data_q[tx0][39:32]));
                end
            end
            OP_RX_ARM: begin
                rx_avail    = take_bits(1) == 8'd1;
                rx_byte     = take_bits(8);
                armed_valid = rx_avail;
                armed_byte  = rx_byte;
                read_op(FROMHOST, got);
                wait_idle();
                check_value(row_name[i], row_exp[i], got);
                check_true(!rx_avail, {row_name[i], ": waiting byte was not fetched"});
            end
            default: begin
                // device code in the top byte, command code below it
                exp = 64'd0;
                if (armed_valid)
                    exp = (64'(`CONSOLE_DEV) << 56) | (64'(`CONSOLE_CMD_WRITE) << 48)
                        | 64'(armed_byte);
                read_op(FROMHOST, got);
                wait_idle();
                check_value(row_name[i], exp, got);
            end
        endcase
    endtask

    initial begin
        rst = 1'b1;
        core_aw_i = '0;
        core_w_i  = '0;
        core_ar_i = '0;
        {core_b_ready_i, core_r_ready_i} = 2'b00;
        {mem_aw_ready_i, mem_w_ready_i, mem_ar_ready_i} = 3'b111;
        mem_b_i = '0;
        mem_r_i = '0;
        lfsr_q = 32'h39ed_75fb;
        {uart_acc, tx_full_left, n_checks, val_errs, other_errs} = '0;
        {rx_avail, rx_byte, armed_valid, armed_byte} = '0;

        set_row(0,  OP_WRITE,    64'h2000, 64'h1122_3344_5566_7788, 64'h0, "pass_wr");
        set_row(1,  OP_READ,     64'h2000, 64'h0, 64'h1122_3344_5566_7788, "pass_rd");
        set_row(2,  OP_READ,     64'h2040, 64'h0, 64'hffff_dfbf_0000_2040, "pass_rd_fill");
        set_row(3,  OP_WRITE,    TOHOST, 64'hdead_beef, 64'h0, "tohost_plain_wr");
        set_row(4,  OP_READ,     TOHOST, 64'h0, 64'h0, "tohost_rd");
        set_row(5,  OP_CONSOLE,  TOHOST, 64'h48, 64'h0, "con_h");
        set_row(6,  OP_READ,     TOHOST, 64'h0, 64'h0, "tohost_after_con");
        set_row(7,  OP_CONSOLE,  TOHOST, 64'h69, 64'h0, "con_i");
        set_row(8,  OP_CONSOLE,  TOHOST, 64'h0a, 64'h0, "con_nl");
        set_row(9,  OP_READ,     TOHOST, 64'h0, 64'h0, "tohost_after_nl");
        set_row(10, OP_RX_ARM,   FROMHOST, 64'h0, 64'h0, "rx_arm0");
        set_row(11, OP_RX_CHECK, FROMHOST, 64'h0, 64'h0, "rx_check0");
        set_row(12, OP_WRITE,    FROMHOST, 64'h0, 64'h0, "fromhost_clr0");
        set_row(13, OP_READ,     FROMHOST, 64'h0, 64'h0, "fromhost_rd0");
        set_row(14, OP_RX_ARM,   FROMHOST, 64'h0, 64'h0, "rx_arm1");
        set_row(15, OP_RX_CHECK, FROMHOST, 64'h0, 64'h0, "rx_check1");
        set_row(16, OP_WRITE,    FROMHOST, 64'h0, 64'h0, "fromhost_clr1");
        set_row(17, OP_RX_ARM,   FROMHOST, 64'h0, 64'h0, "rx_arm2");
        set_row(18, OP_RX_CHECK, FROMHOST, 64'h0, 64'h0, "rx_check2");
        set_row(19, OP_READ,     64'h2000, 64'h0, 64'h1122_3344_5566_7788, "pass_rd_end");

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_true(!core_b_o.valid && !core_r_o.valid, "core valid high after reset");
        check_true(!mem_aw_o.valid && !mem_w_o.valid && !mem_ar_o.valid,
                   "memory valid high after reset");
        check_true(!mem_b_ready_o && !mem_r_ready_o, "memory ready high after reset");

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end

        $display("checks %0d, value errors %0d, other errors %0d",
                 n_checks, val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* htif_bridge.f */
+incdir+.
htif_pkg.sv
htif_route.sv
htif_regs.sv
uart_lite_master.sv
htif_bridge.sv
tb_htif_bridge.sv

/* run.sh */
#!/bin/sh
# build and run the HTIF bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f htif_bridge.f --top-module tb_htif_bridge \
    -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
